// ==== src/isaPkg.sv ====
`default_nettype none

package isaPkg;

  // Data and address word
  typedef logic [31:0] wordT;

  // Opcode byte, zero is Stall so cleared memory parks the core
  typedef enum logic [7:0] {
    Stall     = 8'h00,
    MovRC     = 8'h01,
    MovRR,
    MovRdC,
    MovRdR,
    MovRdRo,
    MovRdRoR,
    MovdCR,
    MovdRoR,
    MovdRoRR,
    PushR,
    PopR,
    CallR,
    Ret,
    CmpRR,
    CmpRC,
    CmpERRR,
    CmpNeRRR,
    CmpLtRRR,
    CmpGtRRR,
    JmpC,
    JeC,
    JneC,
    JzRC,
    JnzRC,
    AddRRC,
    AddRRR,
    SubRRC,
    SubRRR,
    IncR,
    DecR,
    ShlRRR,
    ShrRRR,
    NegRR,
    MulAddRRC
  } opcodeT;

  // Field positions in the first instruction word
  localparam int opcodeLsb = 0;
  localparam int opcodeW   = 8;
  localparam int regALsb   = 8;
  localparam int regBLsb   = 16;
  localparam int regCLsb   = 24;

  localparam wordT instrBytes     = 32'd4;  // Short form
  localparam wordT longInstrBytes = 32'd8;  // Opcode word plus constant word
  localparam wordT stackStep      = 32'd4;

endpackage

`default_nettype wire

// ==== src/corePkg.sv ====
`default_nettype none

package corePkg;

  // One step per cycle, one instruction in flight
  typedef enum logic [3:0] {
    Fetch,
    FetchWait,
    Decode,
    OperandRead,
    ConstWait,
    ConstDone,
    MemIssue,
    MemWait,
    MemDone,
    Execute
  } stepStateT;

  localparam int spReg   = 0;  // Stack pointer
  localparam int flagReg = 1;  // Compare flags

  // Bits of the flag register
  localparam int flagEq = 0;
  localparam int flagLt = 1;
  localparam int flagGt = 2;

endpackage

`default_nettype wire

// ==== src/stepSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module stepSequencer (
  input  logic               clk,
  input  logic               reset,
  input  logic               isLong,   // Constant word follows the opcode word
  input  logic               isRamOp,  // Data read or write needed
  output corePkg::stepStateT state
);
  import corePkg::*;

  stepStateT nextState;

  // Decoder levels are settled from OperandRead onwards
  always_comb begin
    case (state)
      Fetch:       nextState = FetchWait;
      FetchWait:   nextState = Decode;
      Decode:      nextState = OperandRead;
      OperandRead: begin
        if (isLong) begin
          nextState = ConstWait;
        end else if (isRamOp) begin
          nextState = MemIssue;
        end else begin
          nextState = Execute;
        end
      end
      ConstWait:   nextState = ConstDone;
      ConstDone: begin
        // Constant captured, data access may need it as address
        if (isRamOp) begin
          nextState = MemIssue;
        end else begin
          nextState = Execute;
        end
      end
      MemIssue:    nextState = MemWait;   // Strobe cycle
      MemWait:     nextState = MemDone;
      MemDone:     nextState = Execute;   // Load word sampled here
      Execute:     nextState = Fetch;
      default:     nextState = Fetch;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= Fetch;
    end else begin
      state <= nextState;
    end
  end

endmodule

`default_nettype wire

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrDecoder #(
  parameter int regCount = 64
) (
  input  logic                         clk,
  input  logic                         reset,
  input  corePkg::stepStateT           state,
  input  isaPkg::wordT                 ramIn,
  output isaPkg::opcodeT               opcode,
  output logic [$clog2(regCount)-1:0]  regA,
  output logic [$clog2(regCount)-1:0]  regB,
  output logic [$clog2(regCount)-1:0]  regC,
  output logic                         isLong,
  output logic                         isRamOp
);
  import isaPkg::*;
  import corePkg::*;

  localparam int idxW = $clog2(regCount);

  logic   primed;   // Low until the first Decode has passed
  opcodeT fetched;

  // The first Fetch after reset carries no strobe, so that slot runs as a Stall
  assign fetched = primed ? opcodeT'(ramIn[opcodeLsb +: opcodeW]) : Stall;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      opcode <= Stall;
      regA   <= '0;
      regB   <= '0;
      regC   <= '0;
      primed <= 1'b0;
    end else if (state == Decode) begin
      opcode <= fetched;
      regA   <= ramIn[regALsb +: idxW];  // Upper field bits ignored
      regB   <= ramIn[regBLsb +: idxW];
      regC   <= ramIn[regCLsb +: idxW];
      primed <= 1'b1;
    end
  end

  // Opcode classes, unknown codes fall out as short no-ops
  always_comb begin
    case (opcode)
      MovRC, MovRdC, MovRdRo, MovRdRoR, MovdCR, MovdRoR, MovdRoRR, CmpRC,
      JmpC, JeC, JneC, JzRC, JnzRC, AddRRC, SubRRC, MulAddRRC: isLong = 1'b1;
      default: isLong = 1'b0;
    endcase
    case (opcode)
      MovRdC, MovRdR, MovRdRo, MovRdRoR, MovdCR, MovdRoR, MovdRoRR,
      PushR, PopR, CallR, Ret: isRamOp = 1'b1;
      default: isRamOp = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile #(
  parameter int regCount = 64
) (
  input  logic                         clk,
  input  logic                         reset,
  input  corePkg::stepStateT           state,
  input  logic [$clog2(regCount)-1:0]  regA,
  input  logic [$clog2(regCount)-1:0]  regB,
  input  logic [$clog2(regCount)-1:0]  regC,
  input  logic                         destWe,
  input  logic [$clog2(regCount)-1:0]  destIdx,
  input  isaPkg::wordT                 destVal,
  input  logic                         spWe,
  input  isaPkg::wordT                 spNext,
  output isaPkg::wordT                 valA,
  output isaPkg::wordT                 valB,
  output isaPkg::wordT                 valC,
  output isaPkg::wordT                 spVal,
  output isaPkg::wordT                 flagVal
);
  import isaPkg::*;
  import corePkg::*;

  wordT regs [regCount];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (destWe) begin
        regs[destIdx] <= destVal;
      end
      // SP update wins over a pop into register 0
      if (spWe) begin
        regs[spReg] <= spNext;
      end
    end
  end

  // Operand latch, held through the rest of the instruction
  always_ff @(posedge clk) begin
    if (state == OperandRead) begin
      valA <= regs[regA];
      valB <= regs[regB];
      valC <= regs[regC];
    end
  end

  assign spVal   = regs[spReg];
  assign flagVal = regs[flagReg];

endmodule

`default_nettype wire

// ==== src/memoryPort.sv ====
`timescale 1ns/1ns
`default_nettype none

module memoryPort (
  input  logic               clk,
  input  logic               reset,
  input  corePkg::stepStateT state,
  input  isaPkg::opcodeT     opcode,
  input  logic               isLong,
  input  isaPkg::wordT       ipointer,
  input  isaPkg::wordT       valA,
  input  isaPkg::wordT       valB,
  input  isaPkg::wordT       valC,
  input  isaPkg::wordT       spVal,
  input  isaPkg::wordT       ramIn,
  output isaPkg::wordT       ramAddress,
  output isaPkg::wordT       ramOut,
  output logic               readReq,
  output logic               writeReq,
  output isaPkg::wordT       constWord,
  output isaPkg::wordT       loadWord
);
  import isaPkg::*;
  import corePkg::*;

  logic fetchArmed;  // Set from the first edge after reset
  logic isLoad;
  logic isStore;
  wordT dataAddr;

  // Data access per opcode
  always_comb begin
    isLoad   = 1'b0;
    isStore  = 1'b0;
    dataAddr = spVal;
    ramOut   = valB;
    case (opcode)
      MovRdC:   begin isLoad = 1'b1; dataAddr = constWord; end
      MovRdR:   begin isLoad = 1'b1; dataAddr = valB; end
      MovRdRo:  begin isLoad = 1'b1; dataAddr = constWord + valB; end
      MovRdRoR: begin isLoad = 1'b1; dataAddr = valB + constWord * valC; end  // Scaled index
      PopR, Ret: begin isLoad = 1'b1; dataAddr = spVal - stackStep; end      // Top of stack
      MovdCR:   begin isStore = 1'b1; dataAddr = constWord; end
      MovdRoR:  begin isStore = 1'b1; dataAddr = constWord + valA; end
      MovdRoRR: begin isStore = 1'b1; dataAddr = valA + constWord * valB; ramOut = valC; end
      PushR:    begin isStore = 1'b1; ramOut = valA; end
      CallR:    begin isStore = 1'b1; ramOut = ipointer; end  // Return point
      default:  ;
    endcase
  end

  always_comb begin
    case (state)
      OperandRead: ramAddress = ipointer + instrBytes;  // Constant word
      MemIssue:    ramAddress = dataAddr;
      default:     ramAddress = ipointer;
    endcase
  end

  // One-cycle strobes straight from the step state
  assign readReq  = (state == Fetch && fetchArmed) || (state == OperandRead && isLong) ||
                    (state == MemIssue && isLoad);
  assign writeReq = state == MemIssue && isStore;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fetchArmed <= 1'b0;
    end else begin
      fetchArmed <= 1'b1;
    end
  end

  // RAM word is sampled two edges after the strobe edge
  always_ff @(posedge clk) begin
    if (state == ConstDone) begin
      constWord <= ramIn;
    end
    if (state == MemDone) begin
      loadWord <= ramIn;
    end
  end

endmodule

`default_nettype wire

// ==== src/execUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module execUnit #(
  parameter int regCount = 64
) (
  input  logic                         clk,
  input  logic                         reset,
  input  corePkg::stepStateT           state,
  input  isaPkg::opcodeT               opcode,
  input  logic [$clog2(regCount)-1:0]  regA,
  input  logic                         isLong,
  input  isaPkg::wordT                 valA,
  input  isaPkg::wordT                 valB,
  input  isaPkg::wordT                 valC,
  input  isaPkg::wordT                 flagVal,
  input  isaPkg::wordT                 constWord,
  input  isaPkg::wordT                 loadWord,
  input  isaPkg::wordT                 spVal,
  output isaPkg::wordT                 ipointer,
  output logic                         destWe,
  output logic [$clog2(regCount)-1:0]  destIdx,
  output isaPkg::wordT                 destVal,
  output logic                         spWe,
  output isaPkg::wordT                 spNext
);
  import isaPkg::*;
  import corePkg::*;

  localparam int idxW = $clog2(regCount);

  logic condJump;   // Flag-based branch decision
  logic jumpTaken;
  logic writesDest;
  logic isStackOp;
  wordT cmpRhs;
  wordT flagWord;

  // Flag register is stable from OperandRead to Execute
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      condJump <= 1'b0;
    end else if (state == OperandRead) begin
      condJump <= (opcode == JeC && flagVal[flagEq]) || (opcode == JneC && !flagVal[flagEq]);
    end
  end

  // Register C tests use the latched operand
  assign jumpTaken = condJump || (opcode == JzRC && valC == '0) ||
                     (opcode == JnzRC && valC != '0);

  // Compare flags, other bits of the flag register kept
  assign cmpRhs = (opcode == CmpRC) ? constWord : valB;
  always_comb begin
    flagWord         = flagVal;
    flagWord[flagEq] = valA == cmpRhs;
    flagWord[flagLt] = valA < cmpRhs;
    flagWord[flagGt] = valA > cmpRhs;
  end

  always_comb begin
    writesDest = 1'b1;
    destIdx    = regA;
    destVal    = '0;
    case (opcode)
      MovRC:     destVal = constWord;
      MovRR:     destVal = valB;
      MovRdC, MovRdR, MovRdRo, MovRdRoR, PopR: destVal = loadWord;
      CmpRR, CmpRC: begin
        destIdx = idxW'(flagReg);
        destVal = flagWord;
      end
      CmpERRR:   destVal = wordT'(valB == valC);
      CmpNeRRR:  destVal = wordT'(valB != valC);
      CmpLtRRR:  destVal = wordT'(valB < valC);
      CmpGtRRR:  destVal = wordT'(valB > valC);
      AddRRC:    destVal = valB + constWord;
      AddRRR:    destVal = valB + valC;
      SubRRC:    destVal = valB - constWord;
      SubRRR:    destVal = valB - valC;
      IncR:      destVal = valA + 1'b1;
      DecR:      destVal = valA - 1'b1;
      ShlRRR:    destVal = valB << valC;
      ShrRRR:    destVal = valB >> valC;  // Logical
      NegRR:     destVal = -valB;
      MulAddRRC: destVal = valA + valB * constWord;  // Wraps at 32 bits
      default:   writesDest = 1'b0;
    endcase
  end

  assign destWe = state == Execute && writesDest;

  // Stack grows upwards
  assign isStackOp = opcode inside {PushR, PopR, CallR, Ret};
  assign spWe      = state == Execute && isStackOp;
  assign spNext    = (opcode == PushR || opcode == CallR) ? spVal + stackStep
                                                          : spVal - stackStep;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ipointer <= '0;
    end else if (state == Execute) begin
      if (opcode == CallR) begin
        ipointer <= valA;
      end else if (opcode == Ret) begin
        ipointer <= loadWord + instrBytes;  // Skip the call itself
      end else if (opcode == JmpC || jumpTaken) begin
        ipointer <= constWord;
      end else if (opcode != Stall) begin
        ipointer <= ipointer + (isLong ? longInstrBytes : instrBytes);
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/cpuCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuCore #(
  parameter int regCount = 64
) (
  input  logic         clk,
  input  logic         reset,
  input  isaPkg::wordT ramIn,
  output isaPkg::wordT ramAddress,
  output isaPkg::wordT ramOut,
  output logic         readReq,
  output logic         writeReq
);
  import isaPkg::*;
  import corePkg::*;

  localparam int idxW = $clog2(regCount);

  stepStateT       state;
  opcodeT          opcode;
  logic [idxW-1:0] regA;
  logic [idxW-1:0] regB;
  logic [idxW-1:0] regC;
  logic            isLong;
  logic            isRamOp;
  wordT            valA;
  wordT            valB;
  wordT            valC;
  wordT            spVal;    // Current stack pointer
  wordT            flagVal;
  wordT            constWord;
  wordT            loadWord;
  wordT            ipointer;
  logic            destWe;
  logic [idxW-1:0] destIdx;
  wordT            destVal;
  logic            spWe;
  wordT            spNext;   // Stack pointer after push/pop/call/ret

  stepSequencer i_seq (
    .clk(clk), .reset(reset), .isLong(isLong), .isRamOp(isRamOp), .state(state)
  );

  instrDecoder #(.regCount(regCount)) i_dec (
    .clk(clk), .reset(reset), .state(state), .ramIn(ramIn), .opcode(opcode),
    .regA(regA), .regB(regB), .regC(regC), .isLong(isLong), .isRamOp(isRamOp)
  );

  regFile #(.regCount(regCount)) i_regs (
    .clk(clk), .reset(reset), .state(state), .regA(regA), .regB(regB), .regC(regC),
    .destWe(destWe), .destIdx(destIdx), .destVal(destVal), .spWe(spWe), .spNext(spNext),
    .valA(valA), .valB(valB), .valC(valC), .spVal(spVal), .flagVal(flagVal)
  );

  memoryPort i_mem (
    .clk(clk), .reset(reset), .state(state), .opcode(opcode), .isLong(isLong),
    .ipointer(ipointer), .valA(valA), .valB(valB), .valC(valC), .spVal(spVal),
    .ramIn(ramIn), .ramAddress(ramAddress), .ramOut(ramOut), .readReq(readReq),
    .writeReq(writeReq), .constWord(constWord), .loadWord(loadWord)
  );

  execUnit #(.regCount(regCount)) i_exec (
    .clk(clk), .reset(reset), .state(state), .opcode(opcode), .regA(regA),
    .isLong(isLong), .valA(valA), .valB(valB), .valC(valC), .flagVal(flagVal),
    .constWord(constWord), .loadWord(loadWord), .spVal(spVal), .ipointer(ipointer),
    .destWe(destWe), .destIdx(destIdx), .destVal(destVal), .spWe(spWe), .spNext(spNext)
  );

endmodule

`default_nettype wire

// ==== dv/cpuCoreAsserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuCoreAsserts (
  input logic clk,
  input logic reset,
  input logic readReq,
  input logic writeReq
);

  int failures = 0;  // Assertion failures so far

  // One access at a time
  strobesExclusive: assert property (
    @(posedge clk) disable iff (reset) !(readReq && writeReq)
  ) else begin
    failures++;
    $error("readReq and writeReq high in the same cycle");
  end

  readPulse: assert property (
    @(posedge clk) disable iff (reset) readReq |=> !readReq
  ) else begin
    failures++;
    $error("readReq held longer than one cycle");
  end

  writePulse: assert property (
    @(posedge clk) disable iff (reset) writeReq |=> !writeReq
  ) else begin
    failures++;
    $error("writeReq held longer than one cycle");
  end

  // Bus quiet while reset is high
  quietInReset: assert property (
    @(posedge clk) reset |-> !readReq && !writeReq
  ) else begin
    failures++;
    $error("RAM strobe active during reset");
  end

endmodule

`default_nettype wire

// ==== dv/cpuCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuCoreTb;

  localparam int ramWords   = 1024;   // 4 KiB RAM model
  localparam int headerBase = 'h300;  // Word index of the expected-write region
  localparam int parkCycles = 24;     // Longer than the longest instruction

  logic        clk;
  logic        reset;
  logic [31:0] ramIn;
  logic [31:0] ramAddress;
  logic [31:0] ramOut;
  logic        readReq;
  logic        writeReq;

  logic [31:0] image   [ramWords];  // Raw file contents
  logic [31:0] ram     [ramWords];  // Live RAM model
  logic [31:0] ramInit [ramWords];  // RAM right after loading

  integer      seed;
  int          errors;
  int          writesSeen;
  int          expIdx;              // Next write entry in image
  int          cycles;
  int          cycleLimit;
  int          stableCycles;        // Cycles with an unchanged ipointer
  logic        firstReqSeen;
  logic        finished;
  logic [31:0] lastIp;
  logic [31:0] instrCount;
  logic [31:0] progWords;
  logic [31:0] finalIp;

  cpuCore #(.regCount(64)) i_dut (
    .clk(clk), .reset(reset), .ramIn(ramIn), .ramAddress(ramAddress), .ramOut(ramOut),
    .readReq(readReq), .writeReq(writeReq)
  );

  // Strobe protocol checks inside every core instance
  bind cpuCore cpuCoreAsserts i_asserts (
    .clk(clk), .reset(reset), .readReq(readReq), .writeReq(writeReq)
  );

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // Next entry is kind, byte address, value
  task automatic checkWrite();
    logic [31:0] kind;
    logic [31:0] expAddr;
    logic [31:0] expVal;
    kind    = image[expIdx];
    expAddr = image[expIdx + 1];
    expVal  = image[expIdx + 2];
    if (kind == 0) begin
      errors++;
      $display("Unexpected write of 0x%h to 0x%h after the last expected write",
               ramOut, ramAddress);
    end else begin
      if (kind == 2) begin
        expVal = ramInit[expVal[11:2]];  // Word placed by the random fill
      end
      compareValue("ramAddress", ramAddress, expAddr);
      compareValue("ramOut", ramOut, expVal);
      expIdx += 3;
      writesSeen++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Read data shows up from the cycle after the strobe and stays until the next read
  always @(posedge clk) begin
    if (readReq) begin
      ramIn <= ram[ramAddress[11:2]];
    end
    if (writeReq) begin
      ram[ramAddress[11:2]] <= ramOut;
    end
  end

  // Strobes sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && (readReq || writeReq) && !firstReqSeen) begin
      firstReqSeen = 1'b1;
      compareValue("readReq", {31'b0, readReq}, 32'd1);  // Instruction fetch first
      compareValue("ramAddress", ramAddress, 32'd0);
    end
    if (!reset && writeReq) begin
      checkWrite();
    end
  end

  initial begin
    seed         = 72;
    errors       = 0;
    writesSeen   = 0;
    cycles       = 0;
    stableCycles = 0;
    firstReqSeen = 1'b0;
    finished     = 1'b0;
    lastIp       = '0;
    reset        = 1'b1;
    ramIn        = '0;
    $readmemh("dv/programInput.hex", image);
    instrCount = image[headerBase];
    progWords  = image[headerBase + 1];
    finalIp    = image[headerBase + 2];
    expIdx     = headerBase + 3;
    for (int i = 0; i < ramWords; i++) begin
      if (i < progWords) begin
        ram[i] = image[i];
      end else begin
        ram[i] = $random(seed);  // Known data for the loads
      end
      ramInit[i] = ram[i];
    end
    cycleLimit = 12 * instrCount * 4;

    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // Done once the write list is used up and the core sits on a Stall
    while (!finished && cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
      if (i_dut.ipointer == lastIp) begin
        stableCycles++;
      end else begin
        stableCycles = 0;
      end
      lastIp   = i_dut.ipointer;
      finished = image[expIdx] == 0 && stableCycles >= parkCycles;
    end

    if (finished !== 1'b1) begin
      errors++;
      $display("Timeout after %0d cycles, the program did not reach its final Stall", cycles);
    end else begin
      compareValue("ipointer", i_dut.ipointer, finalIp);  // Parked on the right Stall
    end
    errors += i_dut.i_asserts.failures;  // Strobe protocol violations
    $display("Errors: %0d, writes checked: %0d, cycles: %0d", errors, writesSeen, cycles);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/programInput.hex ====
// Program from word 0: instruction words {C, B, A, opcode}, long forms followed by their constant
// At @300: executed instruction count, program words, final ipointer
// Then one expected write per line: kind, byte address, value; kind 1 is a literal value,
// kind 2 means the initial RAM word at byte address value, kind 0 ends the list
00000001 00000E00 00000201 12345678 // 000 r0 = E00 stack, r2
00000301 9ABCDEF0 00000701 00000004 // 010 r3, r7 = 4
0302041A 00040007 00000C00 // 020 add r4 = r2 + r3, store
00030419 70000000 00040007 00000C04 // 02C r4 = r3 + const, store
0302041C 00040007 00000C08 // 03C r4 = r2 - r3, store
0002041B 20000000 00040007 00000C0C // 048 r4 = r2 - const, store
0000031D 00030007 00000C10 // 058 inc r3, store
0000021E 00020007 00000C14 // 064 dec r2, store
0703041F 00040007 00000C18 // 070 r4 = r3 << r7, store
07030420 00040007 00000C1C // 07C r4 = r3 >> r7, store
00020421 00040007 00000C20 // 088 r4 = -r2, store
00020722 00000003 00070007 00000C24 // 094 r7 += r2 * 3, store
00000801 00000800 00000903 00000804 // 0A4 r8 = 800, r9 = [804]
00090007 00000C28 00080904 00090007 00000C2C // 0B4 store, r9 = [r8], store
00080905 00000010 00090007 00000C30 // 0C8 r9 = [10 + r8], store
00000A01 00000005 0A080906 00000008 00090007 00000C34 // 0D8 r10 = 5, r9 = [r8 + 8*r10]
0003020E 00010007 00000C38 // 0F0 cmp r2, r3, store flags
00000015 000001F4 00000016 00000114 00010007 00000CFC // 0FC je not taken, jne taken
0000020F 12345677 00000015 0000012C 00010007 00000CFC // 114 cmp r2, const, je taken
00000016 000001F4 00010007 00000C3C // 12C jne not taken, store flags
02020B10 03020C11 02030D12 02030E13 // 13C r11..r14 three-register compares
0D000017 0000015C 00010007 00000CFC // 14C jz r13 taken
0E000017 000001F4 0B000018 00000174 00010007 00000CFC // 15C jz r14 not, jnz r11 taken
0D000018 000001F4 000C0007 00000C40 000D0007 00000C44 // 174 jnz r13 not, store r12 r13
00000014 0000019C 00010007 00000CFC 000E0007 00000C48 // 18C jmp over, store r14
00000F01 000001E4 0000020A 00000F0C // 1A4 r15 = sub, push r2, call r15
0000100B 00100007 00000C50 // 1B4 pop r16, store
00001101 00000C60 00031108 00000008 // 1C0 r17 = C60, [r17 + 8] = r3
00001201 00000003 07121109 00000010 // 1D0 r18 = 3, [r17 + 10*r18] = r7
00000000 // 1E0 final Stall
00021302 00130007 00000C4C 0000000D // 1E4 sub: r19 = r2, store, ret
00010007 00000CFC 00000000 // 1F4 wrong path: stray store, Stall
@300
00000043 00000080 000001E0
00000001 00000C00 ACF13568
00000001 00000C04 0ABCDEF0
00000001 00000C08 77777788
00000001 00000C0C F2345678
00000001 00000C10 9ABCDEF1
00000001 00000C14 12345677
00000001 00000C18 ABCDEF10
00000001 00000C1C 09ABCDEF
00000001 00000C20 EDCBA989
00000001 00000C24 369D0369
00000002 00000C28 00000804
00000002 00000C2C 00000800
00000002 00000C30 00000810
00000002 00000C34 00000828
00000001 00000C38 00000002
00000001 00000C3C 00000001
00000001 00000C40 00000001
00000001 00000C44 00000000
00000001 00000C48 00000001
00000001 00000E00 12345677
00000001 00000E04 000001B0
00000001 00000C4C 12345677
00000001 00000C50 12345677
00000001 00000C68 9ABCDEF1
00000001 00000C90 369D0369
00000000 00000000 00000000

// ==== flist.f ====
src/isaPkg.sv
src/corePkg.sv
src/stepSequencer.sv
src/instrDecoder.sv
src/regFile.sv
src/memoryPort.sv
src/execUnit.sv
src/cpuCore.sv
dv/cpuCoreAsserts.sv
dv/cpuCoreTb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - src/isaPkg.sv
  - src/corePkg.sv
  - src/stepSequencer.sv
  - src/instrDecoder.sv
  - src/regFile.sv
  - src/memoryPort.sv
  - src/execUnit.sv
  - src/cpuCore.sv
  - target: test
    files:
      - dv/cpuCoreAsserts.sv
      - dv/cpuCoreTb.sv
